//--- verilog.f
hdl/alut_pkg.sv
hdl/alut_reg_bank.sv
hdl/alut_addr_checker.sv
hdl/alut_age_checker.sv
hdl/alut_mem.sv
hdl/alut_top.sv
tb/alut_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f verilog.f --top-module alut_tb -o alut_sim
out=$(./obj_dir/alut_sim)
echo "$out"
if echo "$out" | grep -q "^TEST OK$"; then
   exit 0
fi
exit 1

//--- tb/alut_tb.sv
`timescale 1ns/1ps

module alut_tb;

   localparam int max_cycles  = 6000;   // about twice the longest run
   localparam int wait_cycles = 400;    // long enough to age every old entry

   logic         pclk30;
   logic         n_p_reset30;
   logic         psel;
   logic         penable;
   logic         pwrite;
   logic [6:0]   paddr;
   logic [31:0]  pwdata;
   logic [31:0]  prdata;

   logic [31:0]  lfsr;
   int           errors;
   int           cycles;

   // generated addresses and the ports they are learned on
   logic [47:0]  addr_tab [16];
   logic [1:0]   port_tab [16];

   alut_top u_alut_top (.*);

   initial
   begin
      pclk30 = 1'b0;
      forever #50 pclk30 = ~pclk30;
   end

   // runaway guard
   always @(posedge pclk30)
   begin
      cycles++;
      if (cycles >= max_cycles)
      begin
         $display("timeout: the run did not finish within %0d cycles", max_cycles);
         $display("TEST FAILED");
         $finish;
      end
   end

   // --------------------
   // random source
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // galois form
   endfunction

   task automatic rand_bits(input int n, output logic [47:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v    = {v[46:0], lfsr[0]};   // one step per bit
         lfsr = lfsr_step(lfsr);
      end
   endtask

   // --------------------
   // apb master, driven on the falling edge
   task automatic apb_write(input logic [6:0] a, input logic [31:0] d);
      @(negedge pclk30);
      psel    = 1'b1;
      pwrite  = 1'b1;
      penable = 1'b0;
      paddr   = a;
      pwdata  = d;
      @(negedge pclk30);
      penable = 1'b1;   // write lands at the next rising edge
      @(negedge pclk30);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input logic [6:0] a, output logic [31:0] d);
      @(negedge pclk30);
      psel    = 1'b1;
      pwrite  = 1'b0;
      penable = 1'b0;
      paddr   = a;
      @(negedge pclk30);
      d       = prdata;   // registered at the setup edge
      penable = 1'b1;
      @(negedge pclk30);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp)
      else
      begin
         $display("FAILED %s: expected %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic read_expect(input string name, input logic [6:0] a, input logic [31:0] exp);
      logic [31:0] r;
      apb_read(a, r);
      check_eq(name, exp, r);
   endtask

   // random write, readback masked to the register width
   task automatic reg_rw(input string name, input logic [6:0] a, input logic [31:0] mask);
      logic [47:0] r;
      logic [31:0] rd;
      rand_bits(32, r);
      apb_write(a, r[31:0]);
      apb_read(a, rd);
      check_eq(name, r[31:0] & mask, rd);
   endtask

   // poll until neither sweep runs, last status returned
   task automatic wait_idle(output logic [31:0] st);
      do
         apb_read(alut_pkg::al_status, st);
      while (st[1:0] != 2'b00);
   endtask

   task automatic issue_cmd(input alut_pkg::alut_cmd_e c, output logic [31:0] st);
      apb_write(alut_pkg::al_command, {30'd0, c});
      wait_idle(st);
   endtask

   // learn s on port p, look up d
   task automatic check_cmd(input logic [47:0] s, input logic [1:0] p, input logic [47:0] d,
                            output logic [31:0] dport, output logic [31:0] st);
      apb_write(alut_pkg::al_frm_s_addr_l, s[31:0]);
      apb_write(alut_pkg::al_frm_s_addr_u, {16'd0, s[47:32]});
      apb_write(alut_pkg::al_s_port, {30'd0, p});
      apb_write(alut_pkg::al_frm_d_addr_l, d[31:0]);
      apb_write(alut_pkg::al_frm_d_addr_u, {16'd0, d[47:32]});
      issue_cmd(alut_pkg::cmd_check, st);
      apb_read(alut_pkg::al_d_port, dport);
   endtask

   task automatic lookup(input string name, input logic [47:0] s, input logic [1:0] p,
                         input logic [47:0] d, input logic [31:0] exp);
      logic [31:0] dp;
      logic [31:0] st;
      check_cmd(s, p, d, dp, st);
      check_eq(name, exp, dp);
   endtask

   task automatic check_lst_inv(input string name, input logic [47:0] a, input logic [1:0] p);
      read_expect({name, " addr_l"}, alut_pkg::al_lst_inv_addr_l, a[31:0]);
      read_expect({name, " addr_u"}, alut_pkg::al_lst_inv_addr_u, {16'd0, a[47:32]});
      read_expect({name, " port"}, alut_pkg::al_lst_inv_port, {30'd0, p});
   endtask

   // --------------------
   // directed sequence
   initial
   begin : main
      logic [31:0] rd;
      logic [31:0] st;
      logic [31:0] t0;
      logic [31:0] t1;
      logic [47:0] r;
      logic [47:0] mac;
      n_p_reset30 = 1'b0;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      paddr       = '0;
      pwdata      = '0;
      lfsr        = 32'ha84a1383;
      errors      = 0;
      repeat (16) @(negedge pclk30);
      n_p_reset30 = 1'b1;

      // reset values and register access
      read_expect("reset d_addr_l", alut_pkg::al_frm_d_addr_l, 32'h0);
      read_expect("reset d_addr_u", alut_pkg::al_frm_d_addr_u, 32'h0);
      read_expect("reset s_addr_l", alut_pkg::al_frm_s_addr_l, 32'h0);
      read_expect("reset s_addr_u", alut_pkg::al_frm_s_addr_u, 32'h0);
      read_expect("reset s_port", alut_pkg::al_s_port, 32'h0);
      read_expect("reset mac_l", alut_pkg::al_mac_addr_l, 32'h0);
      read_expect("reset mac_u", alut_pkg::al_mac_addr_u, 32'h0);
      read_expect("reset div_clk", alut_pkg::al_div_clk, 32'h0);
      read_expect("reset status", alut_pkg::al_status, 32'h0);
      read_expect("reset lst_inv_l", alut_pkg::al_lst_inv_addr_l, 32'h0);
      read_expect("reset lst_inv_u", alut_pkg::al_lst_inv_addr_u, 32'h0);
      read_expect("reset lst_inv_port", alut_pkg::al_lst_inv_port, 32'h0);
      read_expect("reset bb_age", alut_pkg::al_bb_age, 32'hffff_ffff);
      reg_rw("rw d_addr_l", alut_pkg::al_frm_d_addr_l, 32'hffff_ffff);
      reg_rw("rw d_addr_u", alut_pkg::al_frm_d_addr_u, 32'h0000_ffff);
      reg_rw("rw s_addr_l", alut_pkg::al_frm_s_addr_l, 32'hffff_ffff);
      reg_rw("rw s_addr_u", alut_pkg::al_frm_s_addr_u, 32'h0000_ffff);
      reg_rw("rw s_port", alut_pkg::al_s_port, 32'h0000_0003);
      reg_rw("rw mac_l", alut_pkg::al_mac_addr_l, 32'hffff_ffff);
      reg_rw("rw mac_u", alut_pkg::al_mac_addr_u, 32'h0000_ffff);
      reg_rw("rw bb_age", alut_pkg::al_bb_age, 32'hffff_ffff);
      reg_rw("rw div_clk", alut_pkg::al_div_clk, 32'h0000_00ff);
      read_expect("command reads 0", alut_pkg::al_command, 32'h0);
      read_expect("undefined offset", 7'h40, 32'h0);

      // --------------------
      // learn and look up
      rand_bits(48, mac);
      apb_write(alut_pkg::al_mac_addr_l, mac[31:0]);
      apb_write(alut_pkg::al_mac_addr_u, {16'd0, mac[47:32]});
      for (int i = 0; i < 13; i++)
      begin
         rand_bits(48, addr_tab[i]);
         rand_bits(2, r);
         port_tab[i] = r[1:0];
      end
      for (int i = 0; i < 4; i++)
      begin
         port_tab[i] = 2'(i);   // entries 0..3 on ports 0..3
         check_cmd(addr_tab[i], port_tab[i], addr_tab[i], rd, st);
      end
      for (int i = 0; i < 4; i++)
         lookup($sformatf("lookup %0d", i), addr_tab[3], port_tab[3], addr_tab[i],
                32'd1 << port_tab[i]);
      lookup("unlearned", addr_tab[3], port_tab[3], addr_tab[10], 32'h0f);
      lookup("own address", addr_tab[3], port_tab[3], mac, 32'h10);
      port_tab[0] = 2'd2;   // move entry 0
      check_cmd(addr_tab[0], port_tab[0], addr_tab[1], rd, st);
      lookup("moved", addr_tab[3], port_tab[3], addr_tab[0], 32'h04);

      // eviction, table full after entry 7
      for (int i = 4; i < 8; i++)
      begin
         check_cmd(addr_tab[i], port_tab[i], addr_tab[i], rd, st);
         check_eq($sformatf("no reuse %0d", i), 32'h0, st & 32'h4);
      end
      check_cmd(addr_tab[8], port_tab[8], addr_tab[8], rd, st);   // victim is entry 0
      check_eq("reused set", 32'h4, st & 32'h4);
      apb_read(alut_pkg::al_status, rd);
      check_eq("reused cleared", 32'h0, rd & 32'h4);
      check_lst_inv("evicted", addr_tab[0], port_tab[0]);

      // --------------------
      // time base and aging
      apb_write(alut_pkg::al_div_clk, 32'd3);
      apb_read(alut_pkg::al_cur_time, t0);
      repeat (197) @(negedge pclk30);
      apb_read(alut_pkg::al_cur_time, t1);   // samples 200 cycles apart
      assert ((t1 - t0 >= 49) && (t1 - t0 <= 51))
      else
      begin
         $display("FAILED time rate: expected 50, actual %0d", t1 - t0);
         errors++;
      end
      apb_write(alut_pkg::al_bb_age, 32'd30);
      repeat (wait_cycles) @(negedge pclk30);
      check_cmd(addr_tab[9], port_tab[9], addr_tab[9], rd, st);   // fresh, lands in entry 1
      apb_read(alut_pkg::al_status, rd);
      issue_cmd(alut_pkg::cmd_age, st);
      check_lst_inv("aged", addr_tab[7], port_tab[7]);   // entry 7 is the last one dropped
      for (int i = 2; i < 9; i++)
         lookup($sformatf("aged %0d", i), addr_tab[9], port_tab[9], addr_tab[i], 32'h0f);
      lookup("fresh", addr_tab[9], port_tab[9], addr_tab[9], 32'd1 << port_tab[9]);

      // clear
      check_cmd(addr_tab[11], port_tab[11], addr_tab[11], rd, st);
      lookup("before clear", addr_tab[9], port_tab[9], addr_tab[11], 32'd1 << port_tab[11]);
      issue_cmd(alut_pkg::cmd_clear, st);
      for (int i = 0; i < 12; i++)
         lookup($sformatf("cleared %0d", i), addr_tab[12], port_tab[12], addr_tab[i], 32'h0f);

      $display("checks done, errors: %0d", errors);
      if (errors == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

//--- hdl/alut_top.sv
`timescale 1ns/1ps

module alut_top
(
   input  logic         pclk30,
   input  logic         n_p_reset30,
   input  logic         psel,
   input  logic         penable,
   input  logic         pwrite,
   input  logic [6:0]   paddr,
   input  logic [31:0]  pwdata,
   output logic [31:0]  prdata
);

   // --------------------
   // reg bank to checkers
   logic [alut_pkg::alut_addr_w-1:0]  mac_addr;
   logic [alut_pkg::alut_addr_w-1:0]  d_addr;
   logic [alut_pkg::alut_addr_w-1:0]  s_addr;
   logic [alut_pkg::alut_port_w-1:0]  s_port;
   logic [31:0]                       best_bfr_age;
   logic [7:0]                        div_clk;
   alut_pkg::alut_cmd_e               command;
   logic                              clear_reused;

   // checkers to reg bank
   logic [31:0]                       curr_time;
   logic                              add_check_active;
   logic                              age_check_active;
   logic                              inval_in_prog;
   logic                              reused;
   logic [4:0]                        d_port;
   logic [alut_pkg::alut_addr_w-1:0]  lst_inv_addr_nrm;
   logic [alut_pkg::alut_port_w-1:0]  lst_inv_port_nrm;
   logic [alut_pkg::alut_addr_w-1:0]  lst_inv_addr_cmd;
   logic [alut_pkg::alut_port_w-1:0]  lst_inv_port_cmd;

   // --------------------
   // table access
   logic                              rd_valid;
   logic [alut_pkg::alut_addr_w-1:0]  rd_addr;
   logic [alut_pkg::alut_port_w-1:0]  rd_port;
   logic [31:0]                       rd_time;
   logic [alut_pkg::alut_idx_w-1:0]   ac_idx;
   logic                              ac_we;
   logic                              ac_wr_valid;
   logic [alut_pkg::alut_addr_w-1:0]  ac_wr_addr;
   logic [alut_pkg::alut_port_w-1:0]  ac_wr_port;
   logic [31:0]                       ac_wr_time;
   logic [alut_pkg::alut_idx_w-1:0]   ag_idx;
   logic                              ag_we;

   // port names line up across blocks
   alut_reg_bank     u_reg_bank     (.*);
   alut_addr_checker u_addr_checker (.*);
   alut_age_checker  u_age_checker  (.*);
   alut_mem          u_mem          (.*);

endmodule

//--- hdl/alut_mem.sv
`timescale 1ns/1ps

module alut_mem
(
   input  logic                              pclk30,
   input  logic                              n_p_reset30,
   input  logic                              add_check_active,
   input  logic [alut_pkg::alut_idx_w-1:0]   ac_idx,
   input  logic                              ac_we,
   input  logic                              ac_wr_valid,
   input  logic [alut_pkg::alut_addr_w-1:0]  ac_wr_addr,
   input  logic [alut_pkg::alut_port_w-1:0]  ac_wr_port,
   input  logic [31:0]                       ac_wr_time,
   input  logic [alut_pkg::alut_idx_w-1:0]   ag_idx,
   input  logic                              ag_we,
   output logic                              rd_valid,
   output logic [alut_pkg::alut_addr_w-1:0]  rd_addr,
   output logic [alut_pkg::alut_port_w-1:0]  rd_port,
   output logic [31:0]                       rd_time
);

   logic [alut_pkg::alut_entries-1:0]  valid;
   logic [alut_pkg::alut_addr_w-1:0]   addr_q [alut_pkg::alut_entries];
   logic [alut_pkg::alut_port_w-1:0]   port_q [alut_pkg::alut_entries];
   logic [31:0]                        time_q [alut_pkg::alut_entries];
   logic [alut_pkg::alut_idx_w-1:0]    idx;
   logic                               we;
   logic                               wr_valid;

   // address checker owns the table during its sweep
   assign idx      = add_check_active ? ac_idx : ag_idx;
   assign we       = add_check_active ? ac_we : ag_we;
   assign wr_valid = add_check_active & ac_wr_valid;   // age writes only invalidate

   always_ff @(posedge pclk30 or negedge n_p_reset30)
   begin
      if (!n_p_reset30)
         valid <= '0;
      else if (we)
         valid[idx] <= wr_valid;
   end

   always_ff @(posedge pclk30)
   begin
      if (we && add_check_active)
      begin
         addr_q[idx] <= ac_wr_addr;
         port_q[idx] <= ac_wr_port;
         time_q[idx] <= ac_wr_time;
      end
   end

   // combinational read
   assign rd_valid = valid[idx];
   assign rd_addr  = addr_q[idx];
   assign rd_port  = port_q[idx];
   assign rd_time  = time_q[idx];

endmodule

//--- hdl/alut_age_checker.sv
`timescale 1ns/1ps

module alut_age_checker
(
   input  logic                              pclk30,
   input  logic                              n_p_reset30,
   input  alut_pkg::alut_cmd_e               command,
   input  logic [7:0]                        div_clk,
   input  logic [31:0]                       best_bfr_age,
   input  logic                              rd_valid,
   input  logic [alut_pkg::alut_addr_w-1:0]  rd_addr,
   input  logic [alut_pkg::alut_port_w-1:0]  rd_port,
   input  logic [31:0]                       rd_time,
   output logic [31:0]                       curr_time,
   output logic                              age_check_active,
   output logic                              inval_in_prog,
   output logic [alut_pkg::alut_addr_w-1:0]  lst_inv_addr_cmd,
   output logic [alut_pkg::alut_port_w-1:0]  lst_inv_port_cmd,
   output logic [alut_pkg::alut_idx_w-1:0]   ag_idx,
   output logic                              ag_we
);

   typedef enum logic {st_idle, st_sweep} state_e;

   state_e                            state;
   logic                              clr_mode;    // clear, not age
   logic [7:0]                        div_cnt;     // prescaler
   logic [31:0]                       age;
   logic                              inval;
   logic                              hit;         // a live entry dropped
   logic [alut_pkg::alut_addr_w-1:0]  held_addr;
   logic [alut_pkg::alut_port_w-1:0]  held_port;

   // --------------------
   // time base
   always_ff @(posedge pclk30 or negedge n_p_reset30)
   begin
      if (!n_p_reset30)
      begin
         div_cnt   <= '0;
         curr_time <= '0;
      end
      else if (div_cnt >= div_clk)   // one tick per div_clk+1 cycles
      begin
         div_cnt   <= '0;
         curr_time <= curr_time + 1'b1;
      end
      else
         div_cnt <= div_cnt + 1'b1;
   end

   // --------------------
   // sweep
   assign age   = curr_time - rd_time;   // wraps mod 2^32
   assign inval = (state == st_sweep) & (clr_mode | (rd_valid & (age > best_bfr_age)));
   assign hit   = inval & rd_valid;

   assign ag_we            = inval;
   assign inval_in_prog    = (state == st_sweep);
   assign age_check_active = (state == st_sweep);

   // bypass so the reg bank sees the final entry before inval_in_prog drops
   assign lst_inv_addr_cmd = hit ? rd_addr : held_addr;
   assign lst_inv_port_cmd = hit ? rd_port : held_port;

   always_ff @(posedge pclk30 or negedge n_p_reset30)
   begin
      if (!n_p_reset30)
      begin
         state     <= st_idle;
         ag_idx    <= '0;
         clr_mode  <= 1'b0;
         held_addr <= '0;
         held_port <= '0;
      end
      else
      begin
         if (state == st_idle)
         begin
            if ((command == alut_pkg::cmd_age) || (command == alut_pkg::cmd_clear))
            begin
               state    <= st_sweep;
               ag_idx   <= '0;
               clr_mode <= (command == alut_pkg::cmd_clear);
            end
         end
         else
         begin
            ag_idx <= ag_idx + 1'b1;
            if (ag_idx == alut_pkg::alut_idx_w'(alut_pkg::alut_entries - 1))
               state <= st_idle;   // eight entries visited
         end
         if (hit)
         begin
            held_addr <= rd_addr;
            held_port <= rd_port;
         end
      end
   end

endmodule

//--- hdl/alut_addr_checker.sv
`timescale 1ns/1ps

module alut_addr_checker
(
   input  logic                              pclk30,
   input  logic                              n_p_reset30,
   input  alut_pkg::alut_cmd_e               command,
   input  logic [alut_pkg::alut_addr_w-1:0]  d_addr,
   input  logic [alut_pkg::alut_addr_w-1:0]  s_addr,
   input  logic [alut_pkg::alut_port_w-1:0]  s_port,
   input  logic [alut_pkg::alut_addr_w-1:0]  mac_addr,
   input  logic [31:0]                       curr_time,
   input  logic                              clear_reused,
   input  logic                              rd_valid,
   input  logic [alut_pkg::alut_addr_w-1:0]  rd_addr,
   input  logic [alut_pkg::alut_port_w-1:0]  rd_port,
   output logic                              add_check_active,
   output logic [4:0]                        d_port,
   output logic                              reused,
   output logic [alut_pkg::alut_addr_w-1:0]  lst_inv_addr_nrm,
   output logic [alut_pkg::alut_port_w-1:0]  lst_inv_port_nrm,
   output logic [alut_pkg::alut_idx_w-1:0]   ac_idx,
   output logic                              ac_we,
   output logic                              ac_wr_valid,
   output logic [alut_pkg::alut_addr_w-1:0]  ac_wr_addr,
   output logic [alut_pkg::alut_port_w-1:0]  ac_wr_port,
   output logic [31:0]                       ac_wr_time
);

   typedef enum logic [1:0] {st_idle, st_scan, st_write} state_e;

   state_e                            state;
   logic [alut_pkg::alut_idx_w-1:0]   scan_idx;     // entry on the read port
   logic [alut_pkg::alut_idx_w-1:0]   rr_ptr;       // next victim when full
   logic                              d_hit;        // destination seen in table
   logic                              s_hit;        // source already learned
   logic                              free_hit;     // an invalid slot exists
   logic [alut_pkg::alut_port_w-1:0]  d_hit_port;
   logic [alut_pkg::alut_idx_w-1:0]   s_idx;
   logic [alut_pkg::alut_idx_w-1:0]   free_idx;     // first invalid slot
   logic [alut_pkg::alut_idx_w-1:0]   tgt_idx;
   logic                              evict;
   logic                              last;

   assign last = (scan_idx == alut_pkg::alut_idx_w'(alut_pkg::alut_entries - 1));

   // own entry first, then a free slot, then the round robin victim
   assign tgt_idx = s_hit ? s_idx : (free_hit ? free_idx : rr_ptr);
   assign evict   = (state == st_write) & ~s_hit & ~free_hit;

   assign add_check_active = (state != st_idle);
   assign ac_idx           = (state == st_write) ? tgt_idx : scan_idx;
   assign ac_we            = (state == st_write);
   assign ac_wr_valid      = 1'b1;   // learned entries are always valid
   assign ac_wr_addr       = s_addr;
   assign ac_wr_port       = s_port;
   assign ac_wr_time       = curr_time;   // stamp for the age sweep

   // --------------------
   // sequencer
   always_ff @(posedge pclk30 or negedge n_p_reset30)
   begin
      if (!n_p_reset30)
      begin
         state    <= st_idle;
         scan_idx <= '0;
         rr_ptr   <= '0;
         d_hit    <= 1'b0;
         s_hit    <= 1'b0;
         free_hit <= 1'b0;
         reused   <= 1'b0;
         d_port   <= '0;
      end
      else
      begin
         case (state)
            st_idle :
               if (command == alut_pkg::cmd_check)
               begin
                  state    <= st_scan;
                  scan_idx <= '0;
                  d_hit    <= 1'b0;
                  s_hit    <= 1'b0;
                  free_hit <= 1'b0;
               end
            st_scan :
            begin
               if (rd_valid && (rd_addr == d_addr))
                  d_hit <= 1'b1;
               if (rd_valid && (rd_addr == s_addr))
                  s_hit <= 1'b1;
               if (!rd_valid)
                  free_hit <= 1'b1;
               scan_idx <= scan_idx + 1'b1;
               if (last)
                  state <= st_write;
            end
            st_write :
            begin
               state <= st_idle;   // entry written at this edge
               if (evict)
                  rr_ptr <= rr_ptr + 1'b1;
               if (d_addr == mac_addr)
                  d_port <= 5'b10000;   // frame for the switch itself
               else if (d_hit)
                  d_port <= 5'b00001 << d_hit_port;
               else
                  d_port <= 5'b01111;   // unknown, flood
            end
            default : state <= st_idle;
         endcase

         if (evict)
            reused <= 1'b1;   // sticky
         else if (clear_reused)
            reused <= 1'b0;
      end
   end

   // scan results and victim capture
   always_ff @(posedge pclk30)
   begin
      if (state == st_scan)
      begin
         if (rd_valid && (rd_addr == d_addr))
            d_hit_port <= rd_port;
         if (rd_valid && (rd_addr == s_addr))
            s_idx <= scan_idx;
         if (!rd_valid && !free_hit)
            free_idx <= scan_idx;
      end
      if (evict)
      begin
         lst_inv_addr_nrm <= rd_addr;   // victim still readable this cycle
         lst_inv_port_nrm <= rd_port;
      end
   end

endmodule

//--- hdl/alut_reg_bank.sv
`timescale 1ns/1ps

module alut_reg_bank
(
   input  logic                              pclk30,
   input  logic                              n_p_reset30,
   input  logic                              psel,
   input  logic                              penable,
   input  logic                              pwrite,
   input  logic [6:0]                        paddr,
   input  logic [31:0]                       pwdata,
   input  logic [31:0]                       curr_time,
   input  logic                              add_check_active,
   input  logic                              age_check_active,
   input  logic                              inval_in_prog,
   input  logic                              reused,
   input  logic [4:0]                        d_port,
   input  logic [alut_pkg::alut_addr_w-1:0]  lst_inv_addr_nrm,
   input  logic [alut_pkg::alut_port_w-1:0]  lst_inv_port_nrm,
   input  logic [alut_pkg::alut_addr_w-1:0]  lst_inv_addr_cmd,
   input  logic [alut_pkg::alut_port_w-1:0]  lst_inv_port_cmd,
   output logic [alut_pkg::alut_addr_w-1:0]  mac_addr,
   output logic [alut_pkg::alut_addr_w-1:0]  d_addr,
   output logic [alut_pkg::alut_addr_w-1:0]  s_addr,
   output logic [alut_pkg::alut_port_w-1:0]  s_port,
   output logic [31:0]                       best_bfr_age,
   output logic [7:0]                        div_clk,
   output alut_pkg::alut_cmd_e               command,
   output logic [31:0]                       prdata,
   output logic                              clear_reused
);

   logic                              read_en;       // setup phase read
   logic                              write_en;      // access phase write
   logic                              active;        // either checker busy
   logic [alut_pkg::alut_addr_w-1:0]  lst_inv_addr;
   logic [alut_pkg::alut_port_w-1:0]  lst_inv_port;

   assign read_en  = psel & ~penable & ~pwrite;
   assign write_en = psel & penable & pwrite;
   assign active   = add_check_active | age_check_active;

   // status read acknowledges reused, but not mid sweep
   assign clear_reused = read_en & (paddr == alut_pkg::al_status) & ~active;

   // --------------------
   // read mux
   always_ff @(posedge pclk30 or negedge n_p_reset30)
   begin
      if (!n_p_reset30)
         prdata <= '0;
      else if (read_en)
      begin
         case (paddr)
            alut_pkg::al_frm_d_addr_l   : prdata <= d_addr[31:0];
            alut_pkg::al_frm_d_addr_u   : prdata <= {16'd0, d_addr[47:32]};
            alut_pkg::al_frm_s_addr_l   : prdata <= s_addr[31:0];
            alut_pkg::al_frm_s_addr_u   : prdata <= {16'd0, s_addr[47:32]};
            alut_pkg::al_s_port         : prdata <= {30'd0, s_port};
            alut_pkg::al_d_port         : prdata <= {27'd0, d_port};
            alut_pkg::al_mac_addr_l     : prdata <= mac_addr[31:0];
            alut_pkg::al_mac_addr_u     : prdata <= {16'd0, mac_addr[47:32]};
            alut_pkg::al_cur_time       : prdata <= curr_time;
            alut_pkg::al_bb_age         : prdata <= best_bfr_age;
            alut_pkg::al_div_clk        : prdata <= {24'd0, div_clk};
            alut_pkg::al_status         : prdata <= {29'd0, reused, inval_in_prog, active};
            alut_pkg::al_lst_inv_addr_l : prdata <= lst_inv_addr[31:0];
            alut_pkg::al_lst_inv_addr_u : prdata <= {16'd0, lst_inv_addr[47:32]};
            alut_pkg::al_lst_inv_port   : prdata <= {30'd0, lst_inv_port};
            default                     : prdata <= '0;   // command and holes
         endcase
      end
      else
         prdata <= '0;   // bus idles low
   end

   // --------------------
   // writable registers
   always_ff @(posedge pclk30 or negedge n_p_reset30)
   begin
      if (!n_p_reset30)
      begin
         d_addr       <= '0;
         s_addr       <= '0;
         s_port       <= '0;
         mac_addr     <= '0;
         best_bfr_age <= 32'hffff_ffff;   // nothing ages by default
         div_clk      <= '0;
      end
      else if (write_en)
      begin
         case (paddr)
            alut_pkg::al_frm_d_addr_l : d_addr[31:0]    <= pwdata;
            alut_pkg::al_frm_d_addr_u : d_addr[47:32]   <= pwdata[15:0];
            alut_pkg::al_frm_s_addr_l : s_addr[31:0]    <= pwdata;
            alut_pkg::al_frm_s_addr_u : s_addr[47:32]   <= pwdata[15:0];
            alut_pkg::al_s_port       : s_port          <= pwdata[1:0];
            alut_pkg::al_mac_addr_l   : mac_addr[31:0]  <= pwdata;
            alut_pkg::al_mac_addr_u   : mac_addr[47:32] <= pwdata[15:0];
            alut_pkg::al_bb_age       : best_bfr_age    <= pwdata;
            alut_pkg::al_div_clk      : div_clk         <= pwdata[7:0];
            default                   : ;
         endcase
      end
   end

   // command pulse, one cycle then back to none
   always_ff @(posedge pclk30 or negedge n_p_reset30)
   begin
      if (!n_p_reset30)
         command <= alut_pkg::cmd_none;
      else if (command != alut_pkg::cmd_none)
         command <= alut_pkg::cmd_none;   // self clear, a back to back write is dropped
      else if (write_en && (paddr == alut_pkg::al_command))
         command <= alut_pkg::alut_cmd_e'(pwdata[1:0]);
   end

   // --------------------
   // last invalidated entry
   // an eviction by the address checker wins over an age or clear sweep
   always_ff @(posedge pclk30 or negedge n_p_reset30)
   begin
      if (!n_p_reset30)
      begin
         lst_inv_addr <= '0;
         lst_inv_port <= '0;
      end
      else if (reused)
      begin
         lst_inv_addr <= lst_inv_addr_nrm;
         lst_inv_port <= lst_inv_port_nrm;
      end
      else if (inval_in_prog)
      begin
         lst_inv_addr <= lst_inv_addr_cmd;
         lst_inv_port <= lst_inv_port_cmd;
      end
   end

endmodule

//--- hdl/alut_pkg.sv
package alut_pkg;

   // --------------------
   // table geometry
   localparam int alut_entries = 8;
   localparam int alut_idx_w   = 3;    // entry index
   localparam int alut_addr_w  = 48;   // mac address
   localparam int alut_port_w  = 2;    // four switch ports

   // --------------------
   // apb register offsets, word aligned
   typedef enum logic [6:0] {
      al_frm_d_addr_l   = 7'h00,   // frame destination, low word
      al_frm_d_addr_u   = 7'h04,
      al_frm_s_addr_l   = 7'h08,   // frame source, low word
      al_frm_s_addr_u   = 7'h0c,
      al_s_port         = 7'h10,
      al_d_port         = 7'h14,   // lookup result, read only
      al_mac_addr_l     = 7'h18,   // own switch address
      al_mac_addr_u     = 7'h1c,
      al_cur_time       = 7'h20,   // read only
      al_bb_age         = 7'h24,
      al_div_clk        = 7'h28,
      al_status         = 7'h2c,   // read only
      al_command        = 7'h30,   // write only, reads 0
      al_lst_inv_addr_l = 7'h34,
      al_lst_inv_addr_u = 7'h38,
      al_lst_inv_port   = 7'h3c
   } alut_reg_e;

   // command codes
   typedef enum logic [1:0] {
      cmd_none  = 2'd0,
      cmd_check = 2'd1,   // learn source, look up destination
      cmd_age   = 2'd2,   // drop stale entries
      cmd_clear = 2'd3    // drop everything
   } alut_cmd_e;

endpackage
